// File: common/str_link_macros.svh
// ####################
// Link-wide constants. The clock to baud ratio must be a whole number.
// The defaults give 16 clocks per bit, which is also the simulation rate.
// ####################
`ifndef STR_LINK_MACROS_SVH
`define STR_LINK_MACROS_SVH

// System clock in Hz. 1.8432 MHz is the classic UART reference clock.
`define UART_CLK_HZ 1_843_200

// Serial data rate in bits per second.
`define UART_BAUD 115_200

// Largest content length of one frame, in characters.
`define STR_MAX_CHARS 128

// Frame delimiter, the ASCII ampersand.
`define STR_DELIM 8'h26

`endif

// File: common/str_link_pkg.sv
// ####################
// Types shared by the string link.
// Character k of a string sits in bits 8k+7 down to 8k.
// ####################
`include "str_link_macros.svh"

package str_link_pkg;

	// Whole string buffer, one byte per character.
	typedef logic [`STR_MAX_CHARS*8-1:0] str_t;

	// Character count. It must hold the value STR_MAX_CHARS itself.
	typedef logic [7:0] str_len_t;

	// Receive status reported with every rx_done pulse.
	typedef struct packed {
		logic frame_err;
		logic overflow;
	} rx_status_t;

endpackage

// File: common/uart_byte_if.sv
// ####################
// Received byte stream from the deserializer to the deframer.
// vld and err are single-cycle pulses and never occur together.
// ####################
`timescale 1ns/1ns

interface uart_byte_if;

	// Last received byte. Stable from the vld or err pulse until the next byte.
	logic [7:0] data;
	// Byte complete with a good stop bit.
	logic       vld;
	// Byte complete with a low stop bit.
	logic       err;
	// A byte is being received.
	logic       busy;

	modport rx_src (
		output data,
		output vld,
		output err,
		output busy
	);

	modport rx_sink (
		input data,
		input vld,
		input err,
		input busy
	);

endinterface

// File: uart/uart_tx.sv
// ####################
// 8N1 serializer. One byte per byte_req, ignored while a byte is on the line.
// byte_done pulses once at the end of the stop bit.
// ####################
`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       serial_out,
	output logic       byte_done
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	// Bit 0 is the start bit, bits 1 to 8 carry data, bit 9 is the stop bit.
	localparam logic [3:0] BIT_LAST_DATA = 4'd8;
	localparam logic [3:0] BIT_STOP = 4'd9;

	logic             active;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_idx;
	logic [7:0]       tx_buf;

	// The byte is captured at the request so the source may change afterwards.
	always_ff @(posedge sys_clk) begin
		if (byte_req && !active) begin
			tx_buf <= byte_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active     <= 1'b0;
			clk_cnt    <= '0;
			bit_idx    <= '0;
			serial_out <= 1'b1;
			byte_done  <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!active) begin
				if (byte_req) begin
					// The start bit goes out on the next cycle.
					active     <= 1'b1;
					clk_cnt    <= '0;
					bit_idx    <= '0;
					serial_out <= 1'b0;
				end
			end else if (clk_cnt == CNT_LAST) begin
				clk_cnt <= '0;
				if (bit_idx == BIT_STOP) begin
					active    <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					// Data goes out LSB first, the stop bit follows the last data bit.
					if (bit_idx == BIT_LAST_DATA) begin
						serial_out <= 1'b1;
					end else begin
						serial_out <= tx_buf[bit_idx[2:0]];
					end
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

// File: uart/uart_rx.sv
// ####################
// 8N1 deserializer. The start bit is checked again at half a bit period.
// Every bit is sampled at its middle; vld or err follows the stop bit.
// ####################
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  logic        serial_in,
	uart_byte_if.rx_src byte_bus
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} rx_state_t;

	rx_state_t        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       rx_shift;
	logic             vld_q;
	logic             err_q;
	logic             sample_data;

	assign sample_data = (state == S_DATA) && (clk_cnt == CNT_LAST);

	// Two flops bring the asynchronous line into the clock domain.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= serial_in;
			rx_sync <= rx_meta;
		end
	end

	// Bits arrive LSB first, so they are shifted in from the top.
	always_ff @(posedge sys_clk) begin
		if (sample_data) begin
			rx_shift <= {rx_sync, rx_shift[7:1]};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= S_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			vld_q   <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			vld_q <= 1'b0;
			err_q <= 1'b0;
			case (state)
				S_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync) begin
						state <= S_START;
					end
				end
				S_START: begin
					if (clk_cnt == CNT_HALF) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// A line that is high again was a glitch.
						state   <= rx_sync ? S_IDLE : S_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt == CNT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (clk_cnt == CNT_LAST) begin
						vld_q <= rx_sync;
						err_q <= !rx_sync;
						state <= S_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign byte_bus.data = rx_shift;
	assign byte_bus.vld  = vld_q;
	assign byte_bus.err  = err_q;
	assign byte_bus.busy = (state != S_IDLE);

endmodule

// File: string/string_framer.sv
// ####################
// Sends "&&", tx_length content bytes and "&&" through the serializer.
// A zero-length request or a request while busy is ignored.
// ####################
`timescale 1ns/1ns
`include "str_link_macros.svh"

module string_framer (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  str_link_pkg::str_t     tx_string,
	input  str_link_pkg::str_len_t tx_length,
	input  logic                  tx_req,
	output logic                  tx_busy,
	output logic                  tx_done,
	output logic [7:0]            byte_data,
	output logic                  byte_req,
	input  logic                  byte_done
);

	import str_link_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_OPEN1,
		S_OPEN2,
		S_CONTENT,
		S_CLOSE1,
		S_CLOSE2,
		S_FINISH
	} tx_state_t;

	tx_state_t  state;
	str_t       str_buf;
	str_len_t   len_buf;
	str_len_t   char_cnt;
	logic       accept;
	logic       send;
	logic [7:0] send_byte;
	logic [7:0] cur_char;

	assign accept   = (state == S_IDLE) && tx_req && (tx_length != '0);
	assign cur_char = str_buf[char_cnt*8 +: 8];

	// Each finished byte launches the next one, so the frame runs back to back.
	always_comb begin
		send      = 1'b0;
		send_byte = `STR_DELIM;
		case (state)
			S_IDLE: send = accept;
			S_OPEN1, S_CLOSE1: send = byte_done;
			S_OPEN2, S_CONTENT: begin
				send = byte_done;
				if (char_cnt != len_buf) begin
					send_byte = cur_char;
				end
			end
			default: send = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_buf <= tx_string;
			len_buf <= tx_length;
		end
		if (send) begin
			byte_data <= send_byte;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			char_cnt <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= send;
			case (state)
				S_IDLE: begin
					char_cnt <= '0;
					if (accept) begin
						state <= S_OPEN1;
					end
				end
				S_OPEN1: if (byte_done) state <= S_OPEN2;
				S_OPEN2: begin
					if (byte_done) begin
						char_cnt <= char_cnt + 8'd1;
						state    <= S_CONTENT;
					end
				end
				S_CONTENT: begin
					if (byte_done) begin
						if (char_cnt == len_buf) begin
							state <= S_CLOSE1;
						end else begin
							char_cnt <= char_cnt + 8'd1;
						end
					end
				end
				S_CLOSE1: if (byte_done) state <= S_CLOSE2;
				S_CLOSE2: if (byte_done) state <= S_FINISH;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign tx_busy = (state != S_IDLE);
	assign tx_done = (state == S_FINISH);

endmodule

// File: string/string_deframer.sv
// ####################
// Finds "&&" framing and assembles the content. A lone "&" in content is kept
// with the byte after it. Content past STR_MAX_CHARS is dropped with overflow.
// A stop-bit error after the first "&" ends the frame with frame_err.
// ####################
`timescale 1ns/1ns
`include "str_link_macros.svh"

module string_deframer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	uart_byte_if.rx_sink            byte_bus,
	output str_link_pkg::str_t       rx_string,
	output str_link_pkg::str_len_t   rx_length,
	output str_link_pkg::rx_status_t rx_status,
	output logic                    rx_busy,
	output logic                    rx_done
);

	import str_link_pkg::*;

	localparam str_len_t LEN_MAX = str_len_t'(`STR_MAX_CHARS);

	typedef enum logic [2:0] {
		S_HUNT,
		S_OPEN,
		S_CONTENT,
		S_PEND,
		S_DONE
	} rx_state_t;

	rx_state_t state;
	logic      is_delim;
	logic      wr_one;
	logic      wr_two;
	logic      room1;
	logic      room2;

	assign is_delim = (byte_bus.data == `STR_DELIM);
	assign wr_one   = (state == S_CONTENT) && byte_bus.vld && !is_delim;
	assign wr_two   = (state == S_PEND) && byte_bus.vld && !is_delim;
	assign room1    = (rx_length < LEN_MAX);
	assign room2    = (rx_length < LEN_MAX - 8'd1);

	// In the pending state the held "&" goes first, then the byte that broke the pair.
	always_ff @(posedge sys_clk) begin
		if (wr_one && room1) begin
			rx_string[rx_length*8 +: 8] <= byte_bus.data;
		end
		if (wr_two && room1) begin
			rx_string[rx_length*8 +: 8] <= `STR_DELIM;
		end
		if (wr_two && room2) begin
			rx_string[(rx_length + 8'd1)*8 +: 8] <= byte_bus.data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_HUNT;
			rx_length <= '0;
			rx_status <= '0;
		end else begin
			case (state)
				S_HUNT: begin
					if (byte_bus.vld && is_delim) begin
						state <= S_OPEN;
					end
				end
				S_OPEN: begin
					if (byte_bus.err) begin
						rx_length <= '0;
						rx_status <= '{frame_err: 1'b1, overflow: 1'b0};
						state     <= S_DONE;
					end else if (byte_bus.vld) begin
						if (is_delim) begin
							// The frame opens here, so the last result is released.
							rx_length <= '0;
							rx_status <= '0;
							state     <= S_CONTENT;
						end else begin
							state <= S_HUNT;
						end
					end
				end
				S_CONTENT: begin
					if (byte_bus.err) begin
						rx_status.frame_err <= 1'b1;
						state               <= S_DONE;
					end else if (byte_bus.vld && is_delim) begin
						state <= S_PEND;
					end else if (wr_one) begin
						if (room1) begin
							rx_length <= rx_length + 8'd1;
						end else begin
							rx_status.overflow <= 1'b1;
						end
					end
				end
				S_PEND: begin
					if (byte_bus.err) begin
						rx_status.frame_err <= 1'b1;
						state               <= S_DONE;
					end else if (byte_bus.vld && is_delim) begin
						state <= S_DONE;
					end else if (wr_two) begin
						state <= S_CONTENT;
						if (room2) begin
							rx_length <= rx_length + 8'd2;
						end else if (room1) begin
							rx_length          <= rx_length + 8'd1;
							rx_status.overflow <= 1'b1;
						end else begin
							rx_status.overflow <= 1'b1;
						end
					end
				end
				default: state <= S_HUNT;
			endcase
		end
	end

	assign rx_busy = (state != S_HUNT);
	assign rx_done = (state == S_DONE);

endmodule

// File: verilog/uart_string_link.sv
// ####################
// UART string link top. Clocks per bit come from UART_CLK_HZ / UART_BAUD.
// Strings up to STR_MAX_CHARS travel as "&&content&&" in 8N1 format.
// ####################
`timescale 1ns/1ns
`include "str_link_macros.svh"

module uart_string_link (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,

	input  str_link_pkg::str_t       tx_string,
	input  str_link_pkg::str_len_t   tx_length,
	input  logic                    tx_req,
	output logic                    tx_busy,
	output logic                    tx_done,

	output str_link_pkg::str_t       rx_string,
	output str_link_pkg::str_len_t   rx_length,
	output str_link_pkg::rx_status_t rx_status,
	output logic                    rx_busy,
	output logic                    rx_done,

	input  logic                    uart_rx_port,
	output logic                    uart_tx_port
);

	localparam int CLKS_PER_BIT = `UART_CLK_HZ / `UART_BAUD;

	logic [7:0] byte_data;
	logic       byte_req;
	logic       byte_done;

	uart_byte_if u_byte_bus ();

	string_framer u_string_framer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (byte_data),
		.byte_req   (byte_req),
		.serial_out (uart_tx_port),
		.byte_done  (byte_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.serial_in (uart_rx_port),
		.byte_bus  (u_byte_bus.rx_src)
	);

	string_deframer u_string_deframer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_bus  (u_byte_bus.rx_sink),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_status (rx_status),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done)
	);

endmodule

// File: sim/tb_uart_string_tasks.svh
// ####################
// Testbench helpers, included inside the testbench module body.
// Serial timing counts DUT clocks, so CLKS_PER_BIT must match the DUT.
// ####################
`ifndef TB_UART_STRING_TASKS_SVH
`define TB_UART_STRING_TASKS_SVH

int error_cnt = 0;
int test_pass_cnt = 0;
int test_fail_cnt = 0;

task automatic report_failure(input string what);
	error_cnt++;
	$display("ERROR at %0t ns: %s", $time, what);
endtask

task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		error_cnt++;
		$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
	end
endtask

// Only the first len characters carry content, the rest of the register is stale.
task automatic compare_str(input string name, input str_t got, input str_t exp,
	input str_len_t len);
	int k;
	int bad;
	bad = -1;
	for (k = 0; k < len && bad < 0; k++) begin
		if (got[k*8 +: 8] !== exp[k*8 +: 8]) begin
			bad = k;
		end
	end
	if (bad >= 0) begin
		error_cnt++;
		$display("MISMATCH at %0t ns: %s char %0d got %h expected %h", $time, name, bad,
			got[bad*8 +: 8], exp[bad*8 +: 8]);
	end
endtask

task automatic compare_len(input string name, input str_len_t got, input str_len_t exp);
	if (got !== exp) begin
		error_cnt++;
		$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic compare_status(input string name, input rx_status_t got, input rx_status_t exp);
	if (got !== exp) begin
		error_cnt++;
		$display("MISMATCH at %0t ns: %s got frame_err=%b overflow=%b expected frame_err=%b overflow=%b",
			$time, name, got.frame_err, got.overflow, exp.frame_err, exp.overflow);
	end
endtask

// Drives one 8N1 byte on the injected line, starting at the current falling edge.
task automatic send_serial_byte(input logic [7:0] b, input bit bad_stop);
	int k;
	inj_line = 1'b0;
	repeat (CLKS_PER_BIT) @(negedge sys_clk);
	for (k = 0; k < 8; k++) begin
		inj_line = b[k];
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
	end
	inj_line = !bad_stop;
	repeat (CLKS_PER_BIT) @(negedge sys_clk);
	if (bad_stop) begin
		// The receiver must see the line high again before it looks for a new start bit.
		inj_line = 1'b1;
		repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
	end
endtask

// Recovers one byte from uart_tx_port by sampling each bit at its middle.
task automatic decode_tx_byte(output logic [7:0] b);
	int k;
	while (uart_tx_port !== 1'b0) begin
		@(negedge sys_clk);
	end
	repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
	if (uart_tx_port !== 1'b0) begin
		report_failure("start bit on uart_tx_port ended too early");
	end
	for (k = 0; k < 8; k++) begin
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		b[k] = uart_tx_port;
	end
	repeat (CLKS_PER_BIT) @(negedge sys_clk);
	if (uart_tx_port !== 1'b1) begin
		report_failure("stop bit on uart_tx_port was low");
	end
endtask

// A frame is two delimiters, the content in index order and two delimiters.
task automatic check_tx_frame(input str_t s, input str_len_t n);
	logic [7:0] got;
	logic [7:0] exp;
	int k;
	for (k = 0; k < n + 4; k++) begin
		decode_tx_byte(got);
		if (k < 2 || k >= n + 2) begin
			exp = `STR_DELIM;
		end else begin
			exp = s[(k - 2)*8 +: 8];
		end
		compare_byte($sformatf("uart_tx_port byte %0d", k), got, exp);
	end
endtask

`endif

// File: sim/tb_uart_string_link.sv
// ####################
// Testbench for the UART string link, run from a table of test entries.
// Loopback entries tie uart_rx_port to uart_tx_port, the others inject bytes.
// ####################
`timescale 1ns/1ns
`include "str_link_macros.svh"

module tb_uart_string_link;

	import str_link_pkg::*;

	localparam int CLKS_PER_BIT = `UART_CLK_HZ / `UART_BAUD;
	localparam int NUM_TESTS = 8;
	localparam int RAW_MAX = 160;
	localparam int MODE_LOOP = 0;
	localparam int MODE_ZERO = 1;
	localparam int MODE_INJECT = 2;

	logic       sys_clk;
	logic       sys_rst_n;
	str_t       tx_string;
	str_len_t   tx_length;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	str_t       rx_string;
	str_len_t   rx_length;
	rx_status_t rx_status;
	logic       rx_busy;
	logic       rx_done;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       loopback;
	logic       inj_line;

	integer     seed;
	longint     watchdog_ns = 0;
	int         tx_done_cnt = 0;
	str_t       cap_str;
	str_len_t   cap_len;
	rx_status_t cap_status;

	// Test table. Injected entries carry their raw byte stream in t_raw.
	string      t_name [NUM_TESTS];
	int         t_mode [NUM_TESTS];
	str_t       t_str [NUM_TESTS];
	str_len_t   t_len [NUM_TESTS];
	logic [7:0] t_raw [NUM_TESTS][RAW_MAX];
	int         t_raw_len [NUM_TESTS];
	int         t_bad_idx [NUM_TESTS];
	str_t       t_exp_str [NUM_TESTS];
	str_len_t   t_exp_len [NUM_TESTS];
	rx_status_t t_exp_status [NUM_TESTS];

	`include "tb_uart_string_tasks.svh"

	assign uart_rx_port = loopback ? uart_tx_port : inj_line;

	uart_string_link u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_status    (rx_status),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		if (tx_done) begin
			tx_done_cnt <= tx_done_cnt + 1;
		end
	end

	// Letters only, so random content never contains the delimiter.
	function automatic logic [7:0] random_letter();
		return 8'h61 + 8'({$random(seed)} % 26);
	endfunction

	task automatic push_raw(input int i, input logic [7:0] b);
		t_raw[i][t_raw_len[i]] = b;
		t_raw_len[i]++;
	endtask

	task automatic push_text(input int i, input string s);
		int k;
		for (k = 0; k < s.len(); k++) begin
			push_raw(i, s[k]);
		end
	endtask

	task automatic set_exp_text(input int i, input string s);
		int k;
		for (k = 0; k < s.len(); k++) begin
			t_exp_str[i][k*8 +: 8] = s[k];
		end
		t_exp_len[i] = str_len_t'(s.len());
	endtask

	task automatic build_table();
		int i;
		int k;
		logic [7:0] c;
		for (i = 0; i < NUM_TESTS; i++) begin
			t_mode[i] = MODE_INJECT;
			t_str[i] = '0;
			t_len[i] = '0;
			t_raw_len[i] = 0;
			t_bad_idx[i] = -1;
			t_exp_str[i] = '0;
			t_exp_len[i] = '0;
			t_exp_status[i] = '0;
		end
		t_name[0] = "loopback length 1";
		t_name[1] = "loopback length 5";
		t_name[2] = "loopback length 128";
		t_len[0] = 8'd1;
		t_len[1] = 8'd5;
		t_len[2] = 8'd128;
		for (i = 0; i < 3; i++) begin
			t_mode[i] = MODE_LOOP;
			for (k = 0; k < t_len[i]; k++) begin
				t_str[i][k*8 +: 8] = random_letter();
			end
			t_exp_str[i] = t_str[i];
			t_exp_len[i] = t_len[i];
		end
		t_name[3] = "zero-length request";
		t_mode[3] = MODE_ZERO;
		t_str[3] = t_str[1];
		// Garbage and a lone delimiter before the frame, then a lone delimiter in content.
		t_name[4] = "hunting and lone delimiter";
		push_text(4, "xy&Q&&ab&Zcd&&");
		set_exp_text(4, "ab&Zcd");
		t_name[5] = "content overflow";
		push_text(5, "&&");
		for (k = 0; k < 130; k++) begin
			c = random_letter();
			push_raw(5, c);
			if (k < `STR_MAX_CHARS) begin
				t_exp_str[5][k*8 +: 8] = c;
			end
		end
		push_text(5, "&&");
		t_exp_len[5] = str_len_t'(`STR_MAX_CHARS);
		t_exp_status[5] = '{frame_err: 1'b0, overflow: 1'b1};
		t_name[6] = "bad stop bit";
		push_text(6, "&&abcd");
		t_bad_idx[6] = 5;
		set_exp_text(6, "abc");
		t_exp_status[6] = '{frame_err: 1'b1, overflow: 1'b0};
		t_name[7] = "good frame after error";
		push_text(7, "&&hello&&");
		set_exp_text(7, "hello");
		for (i = 0; i < NUM_TESTS; i++) begin
			k = (t_mode[i] == MODE_INJECT) ? t_raw_len[i] : t_len[i];
			watchdog_ns += longint'(k + 6) * 10 * CLKS_PER_BIT * 10;
		end
		watchdog_ns = 2 * watchdog_ns;
	endtask

	task automatic wait_tx_done(input int limit);
		int n;
		n = 0;
		while (tx_done !== 1'b1 && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (tx_done !== 1'b1) begin
			report_failure("tx_done did not pulse within the frame time");
		end else begin
			@(negedge sys_clk);
			if (tx_busy !== 1'b0) begin
				report_failure("tx_busy stayed high after tx_done");
			end
		end
	endtask

	task automatic wait_rx_done(input int limit);
		int n;
		bit busy_seen;
		n = 0;
		busy_seen = 1'b0;
		while (rx_done !== 1'b1 && n < limit) begin
			if (rx_busy === 1'b1) begin
				busy_seen = 1'b1;
			end
			@(negedge sys_clk);
			n++;
		end
		if (rx_done !== 1'b1) begin
			report_failure("rx_done did not pulse within the frame time");
		end else begin
			cap_str = rx_string;
			cap_len = rx_length;
			cap_status = rx_status;
			// rx_busy covers the whole frame and drops when rx_done ends.
			if (!busy_seen || rx_busy !== 1'b1) begin
				report_failure("rx_busy was not high while the frame was received");
			end
			@(negedge sys_clk);
			if (rx_busy !== 1'b0) begin
				report_failure("rx_busy stayed high after rx_done");
			end
		end
	endtask

	task automatic check_rx_result(input int i);
		compare_str("rx_string", cap_str, t_exp_str[i], t_exp_len[i]);
		compare_len("rx_length", cap_len, t_exp_len[i]);
		compare_status("rx_status", cap_status, t_exp_status[i]);
	endtask

	task automatic run_loopback(input int i);
		int limit;
		int done_base;
		limit = (t_len[i] + 6) * 10 * CLKS_PER_BIT * 2;
		done_base = tx_done_cnt;
		loopback = 1'b1;
		fork
			begin
				tx_string = t_str[i];
				tx_length = t_len[i];
				tx_req = 1'b1;
				@(negedge sys_clk);
				tx_req = 1'b0;
				if (tx_busy !== 1'b1) begin
					report_failure("tx_busy did not rise after an accepted request");
				end
				// A request in the middle of the frame must leave its bytes alone.
				repeat (3 * CLKS_PER_BIT) @(negedge sys_clk);
				tx_string = ~t_str[i];
				tx_length = 8'd3;
				tx_req = 1'b1;
				@(negedge sys_clk);
				tx_req = 1'b0;
			end
			check_tx_frame(t_str[i], t_len[i]);
			wait_tx_done(limit);
			wait_rx_done(limit);
		join
		repeat (CLKS_PER_BIT) @(negedge sys_clk);
		if (tx_done_cnt != done_base + 1) begin
			report_failure("tx_done did not pulse exactly once for the frame");
		end
		check_rx_result(i);
	endtask

	task automatic run_zero(input int i);
		int done_base;
		bit active;
		done_base = tx_done_cnt;
		active = 1'b0;
		loopback = 1'b1;
		tx_string = t_str[i];
		tx_length = '0;
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		repeat (20 * CLKS_PER_BIT) begin
			if (tx_busy !== 1'b0 || uart_tx_port !== 1'b1) begin
				active = 1'b1;
			end
			@(negedge sys_clk);
		end
		if (active || tx_done_cnt != done_base) begin
			report_failure("zero-length request started a transmission");
		end
	endtask

	task automatic run_inject(input int i);
		int limit;
		int k;
		limit = (t_raw_len[i] + 6) * 10 * CLKS_PER_BIT * 2;
		loopback = 1'b0;
		fork
			begin
				for (k = 0; k < t_raw_len[i]; k++) begin
					send_serial_byte(t_raw[i][k], k == t_bad_idx[i]);
				end
				repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
			end
			wait_rx_done(limit);
		join
		check_rx_result(i);
	endtask

	initial begin
		int i;
		int errs_before;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		loopback = 1'b1;
		inj_line = 1'b1;
		seed = 87344;
		build_table();
		repeat (3) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (4) @(negedge sys_clk);
		for (i = 0; i < NUM_TESTS; i++) begin
			errs_before = error_cnt;
			case (t_mode[i])
				MODE_LOOP: run_loopback(i);
				MODE_ZERO: run_zero(i);
				default: run_inject(i);
			endcase
			if (error_cnt == errs_before) begin
				test_pass_cnt++;
				$display("test %0d %s: ok", i, t_name[i]);
			end else begin
				test_fail_cnt++;
				$display("test %0d %s: failed", i, t_name[i]);
			end
			repeat (2 * CLKS_PER_BIT) @(negedge sys_clk);
		end
		$display("tests run %0d, ok %0d, failed %0d, check errors %0d",
			NUM_TESTS, test_pass_cnt, test_fail_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// The limit allows twice the serial time of every test in the table.
	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("ERROR: timeout after %0d ns, the DUT stopped responding", watchdog_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sources.f
+incdir+common
+incdir+sim
common/str_link_pkg.sv
common/uart_byte_if.sv
uart/uart_tx.sv
uart/uart_rx.sv
string/string_framer.sv
string/string_deframer.sv
verilog/uart_string_link.sv
sim/tb_uart_string_link.sv

// File: Bender.yml
package:
  name: uart_string_link

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/str_link_pkg.sv
      - common/uart_byte_if.sv
      - uart/uart_tx.sv
      - uart/uart_rx.sv
      - string/string_framer.sv
      - string/string_deframer.sv
      - verilog/uart_string_link.sv
  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/tb_uart_string_link.sv
